// ==== fetch_front.f ====
verilog/fetch_pkg.sv
verilog/burst_line_reader.sv
verilog/fetch_ctrl.sv
verilog/inst_queue.sv
verilog/fetch_front.sv
testbench/clock_gen.sv
testbench/bmem_model.sv
testbench/fetch_front_properties.sv
testbench/tb_fetch_front.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_fetch_front \
    -f fetch_front.f \
    -o sim_fetch_front

./obj_dir/sim_fetch_front | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run passed"
else
    echo "run failed"
    exit 1
fi

// ==== testbench/tb_fetch_front.sv ====
`timescale 1ns/1ps

module tb_fetch_front;

    localparam logic [31:0] lfsr_seed     = 32'ha0589a41;
    localparam logic [31:0] mem_pattern   = 32'h13579bdf;
    localparam int          num_redirects = 40;
    localparam int          watchdog_ns   = 2000 * 40 * 20;

    logic                          clk;
    logic                          rst;
    logic                          bmem_ready;
    logic                          bmem_rvalid;
    logic                          bmem_read;
    logic [fetch_pkg::addr_w-1:0]  bmem_raddr;
    logic [fetch_pkg::addr_w-1:0]  bmem_addr;
    logic [fetch_pkg::beat_w-1:0]  bmem_rdata;
    logic                          deq;
    logic                          redirect;
    logic [fetch_pkg::addr_w-1:0]  redirect_pc;
    logic                          inst_valid;
    logic [fetch_pkg::inst_w-1:0]  inst;
    logic [fetch_pkg::addr_w-1:0]  inst_pc;
    logic [fetch_pkg::order_w-1:0] inst_order;
    logic [1:0]                    beat_delay;

    logic [31:0] lfsr_q = lfsr_seed;
    int          stall_left = 0;
    int          errors = 0;
    int          deq_count = 0;

    // scoreboard state
    logic        want_target = 1'b1;
    logic [31:0] target = fetch_pkg::reset_pc;
    logic        have_last = 1'b0;
    logic [31:0] last_pc;
    logic [63:0] last_order;
    logic        skip_deq = 1'b0;
    bit          seen_tags [logic [26:0]];

    clock_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    bmem_model #(.pattern(mem_pattern)) mem_i (
        .clk      (clk),
        .rst      (rst),
        .read_i   (bmem_read),
        .addr_i   (bmem_addr),
        .delay_i  (beat_delay),
        .ready_o  (bmem_ready),
        .rvalid_o (bmem_rvalid),
        .raddr_o  (bmem_raddr),
        .rdata_o  (bmem_rdata)
    );

    fetch_front dut_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .deq_i         (deq),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_valid_o  (inst_valid),
        .inst_o        (inst),
        .inst_pc_o     (inst_pc),
        .inst_order_o  (inst_order)
    );

    bind fetch_front fetch_front_properties props_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_read_o   (bmem_read_o),
        .bmem_addr_o   (bmem_addr_o),
        .inst_valid_o  (inst_valid_o)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
        errors++;
        $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic drive_random();
        if (stall_left != 0) begin
            stall_left--;
            deq = 1'b0;
        end else if (lfsr_bits(6) == 32'd0) begin
            // long back-pressure stretch
            stall_left = 16 + int'(lfsr_bits(5));
            deq        = 1'b0;
        end else begin
            deq = (lfsr_bits(2) != 32'd0);
        end
        beat_delay = 2'(lfsr_bits(2));
    endtask

    task automatic next_cycle();
        @(negedge clk);
        redirect = 1'b0;
        drive_random();
    endtask

    task automatic issue_redirect(input logic [31:0] pc);
        @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = pc;
        drive_random();
        next_cycle();
        next_cycle();
        assert (!inst_valid) else begin
            errors++;
            $display("queue still holds entries two edges after a redirect");
        end
    endtask

    function automatic logic [31:0] pick_target(input logic [1:0] kind);
        if (kind == 2'd2 && have_last) begin
            // somewhere in the line just dequeued, likely still buffered
            return {last_pc[31:5], 3'(lfsr_bits(3)), 2'b00};
        end
        return {8'h40, 22'(lfsr_bits(22)), 2'b00};
    endfunction

    task automatic check_entry();
        assert (inst == (inst_pc ^ mem_pattern))
            else report_value("inst_o", 64'(inst_pc ^ mem_pattern), 64'(inst));
        if (want_target) begin
            assert (inst_pc == target) else report_value("inst_pc_o", 64'(target), 64'(inst_pc));
            // flushed entries may already have used order numbers before a redirect
            if (!have_last && target == fetch_pkg::reset_pc) begin
                assert (inst_order == 64'd0) else report_value("inst_order_o", 64'd0, inst_order);
            end else if (have_last) begin
                assert (inst_order > last_order) else begin
                    errors++;
                    $display("order number did not advance across a redirect");
                end
            end
        end else begin
            assert (inst_pc == last_pc + 32'd4)
                else report_value("inst_pc_o", 64'(last_pc + 32'd4), 64'(inst_pc));
            assert (inst_order == last_order + 64'd1)
                else report_value("inst_order_o", last_order + 64'd1, inst_order);
        end
        want_target = 1'b0;
        have_last   = 1'b1;
        last_pc     = inst_pc;
        last_order  = inst_order;
        deq_count++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (bmem_read) begin
                assert (!seen_tags.exists(bmem_addr[31:5])) else begin
                    errors++;
                    $display("line %h read again without a redirect", bmem_addr);
                end
                seen_tags[bmem_addr[31:5]] = 1'b1;
            end
            // the edge after a redirect flushes, whatever sits at the head
            if (deq && inst_valid && !skip_deq) begin
                check_entry();
            end
            skip_deq = redirect;
            if (redirect) begin
                want_target = 1'b1;
                target      = redirect_pc;
                seen_tags.delete();
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the test sequence finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int          gap;
        int          tries;
        logic [1:0]  kind;
        deq         = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        beat_delay  = '0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        repeat (num_redirects) begin
            gap = 30 + int'(lfsr_bits(7));
            repeat (gap) next_cycle();
            kind = 2'(lfsr_bits(2));
            if (kind == 2'd1) begin
                // land the redirect inside a burst
                tries = 0;
                while (bmem_ready && tries < 100) begin
                    next_cycle();
                    tries++;
                end
            end
            issue_redirect(pick_target(kind));
        end
        repeat (300) next_cycle();
        assert (deq_count > 500) else begin
            errors++;
            $display("too few instructions came out of the queue: %0d", deq_count);
        end
        $display("done: %0d entries, %0d scoreboard errors, %0d property errors",
                 deq_count, errors, dut_i.props_i.fail_cnt);
        if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/fetch_front_properties.sv ====
`timescale 1ns/1ps

module fetch_front_properties (
    input logic        clk,
    input logic        rst,
    input logic        bmem_ready_i,
    input logic        bmem_rvalid_i,
    input logic        bmem_read_o,
    input logic [31:0] bmem_addr_o,
    input logic        inst_valid_o
);

    int fail_cnt = 0;

    // shadow of the bus side, idle or collecting beats
    fetch_pkg::reader_state_t bus_state_q;
    logic [1:0]               beats_q;

    always @(posedge clk) begin
        if (rst) begin
            bus_state_q <= fetch_pkg::rd_idle;
            beats_q     <= '0;
        end else if (bus_state_q == fetch_pkg::rd_idle) begin
            if (bmem_read_o) begin
                bus_state_q <= fetch_pkg::rd_collect;
                beats_q     <= '0;
            end
        end else if (bmem_rvalid_i) begin
            beats_q <= beats_q + 2'd1;
            if (beats_q == 2'd3) begin
                bus_state_q <= fetch_pkg::rd_idle;
            end
        end
    end

    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> bmem_ready_i)
    else begin
        fail_cnt++;
        $error("read strobe while memory not ready");
    end

    // address must hold until the fourth beat is in
    addr_held: assert property (@(posedge clk) disable iff (rst)
        (bus_state_q == fetch_pkg::rd_collect) |-> $stable(bmem_addr_o))
    else begin
        fail_cnt++;
        $error("read address changed while a burst was in flight");
    end

    one_burst_at_a_time: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> (bus_state_q == fetch_pkg::rd_idle))
    else begin
        fail_cnt++;
        $error("second read before four beats returned");
    end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!inst_valid_o && !bmem_read_o))
    else begin
        fail_cnt++;
        $error("outputs active right after reset");
    end

endmodule

// ==== testbench/bmem_model.sv ====
`timescale 1ns/1ps

module bmem_model #(
    parameter logic [31:0] pattern = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        read_i,
    input  logic [31:0] addr_i,
    input  logic [1:0]  delay_i,
    output logic        ready_o,
    output logic        rvalid_o,
    output logic [31:0] raddr_o,
    output logic [63:0] rdata_o
);

    int          req_cnt;
    int          taken_cnt;
    logic [31:0] req_addr;
    logic [31:0] line_addr;
    logic        busy;
    int          beat;
    int          gap;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a ^ pattern;
    endfunction

    initial begin
        ready_o  = 1'b1;
        rvalid_o = 1'b0;
        raddr_o  = '0;
        rdata_o  = '0;
        busy     = 1'b0;
        req_cnt  = 0;
    end

    // read strobes are caught on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            req_cnt <= 0;
        end else if (read_i && ready_o) begin
            req_cnt  <= req_cnt + 1;
            req_addr <= addr_i;
        end
    end

    // beats go out on the falling edge
    always @(negedge clk) begin
        rvalid_o <= 1'b0;
        if (rst) begin
            taken_cnt = 0;
            busy      = 1'b0;
            ready_o  <= 1'b1;
        end else if (!busy) begin
            if (req_cnt != taken_cnt) begin
                taken_cnt = taken_cnt + 1;
                busy      = 1'b1;
                ready_o  <= 1'b0;
                line_addr = req_addr;
                beat      = 0;
                gap       = int'(delay_i);
            end
        end else if (gap != 0) begin
            gap = gap - 1;
        end else begin
            rvalid_o <= 1'b1;
            raddr_o  <= line_addr;
            rdata_o  <= {word_at(line_addr + 32'(8 * beat + 4)),
                         word_at(line_addr + 32'(8 * beat))};
            beat = beat + 1;
            gap  = int'(delay_i);
            if (beat == 4) begin
                busy     = 1'b0;
                ready_o <= 1'b1;
            end
        end
    end

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int half_period_ns = 10,
    parameter int reset_cycles   = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== verilog/fetch_front.sv ====
`timescale 1ns/1ps

module fetch_front (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          bmem_ready_i,
    input  logic [fetch_pkg::addr_w-1:0]  bmem_raddr_i,
    input  logic [fetch_pkg::beat_w-1:0]  bmem_rdata_i,
    input  logic                          bmem_rvalid_i,
    output logic [fetch_pkg::addr_w-1:0]  bmem_addr_o,
    output logic                          bmem_read_o,

    input  logic                          deq_i,
    input  logic                          redirect_i,
    input  logic [fetch_pkg::addr_w-1:0]  redirect_pc_i,

    output logic                          inst_valid_o,
    output logic [fetch_pkg::inst_w-1:0]  inst_o,
    output logic [fetch_pkg::addr_w-1:0]  inst_pc_o,
    output logic [fetch_pkg::order_w-1:0] inst_order_o
);

    // controller to reader
    logic                          line_req;
    logic [fetch_pkg::addr_w-1:0]  line_addr;
    logic                          line_done;
    logic [fetch_pkg::line_w-1:0]  line_data;

    // controller to queue
    logic                          full;
    logic                          enq;
    logic [fetch_pkg::order_w-1:0] enq_order;
    logic [fetch_pkg::addr_w-1:0]  enq_pc;
    logic [fetch_pkg::inst_w-1:0]  enq_inst;
    logic                          flush;

    burst_line_reader reader_i (
        .clk           (clk),
        .rst           (rst),
        .line_req_i    (line_req),
        .line_addr_i   (line_addr),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .line_done_o   (line_done),
        .line_data_o   (line_data)
    );

    fetch_ctrl ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .line_done_i   (line_done),
        .line_data_i   (line_data),
        .full_i        (full),
        .line_req_o    (line_req),
        .line_addr_o   (line_addr),
        .enq_o         (enq),
        .enq_order_o   (enq_order),
        .enq_pc_o      (enq_pc),
        .enq_inst_o    (enq_inst),
        .flush_o       (flush)
    );

    inst_queue queue_i (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush),
        .enq_i         (enq),
        .enq_order_i   (enq_order),
        .enq_pc_i      (enq_pc),
        .enq_inst_i    (enq_inst),
        .deq_i         (deq_i),
        .full_o        (full),
        .valid_o       (inst_valid_o),
        .order_o       (inst_order_o),
        .pc_o          (inst_pc_o),
        .inst_o        (inst_o)
    );

endmodule

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          flush_i,

    input  logic                          enq_i,
    input  logic [fetch_pkg::order_w-1:0] enq_order_i,
    input  logic [fetch_pkg::addr_w-1:0]  enq_pc_i,
    input  logic [fetch_pkg::inst_w-1:0]  enq_inst_i,

    input  logic                          deq_i,

    output logic                          full_o,
    output logic                          valid_o,
    output logic [fetch_pkg::order_w-1:0] order_o,
    output logic [fetch_pkg::addr_w-1:0]  pc_o,
    output logic [fetch_pkg::inst_w-1:0]  inst_o
);

    logic [fetch_pkg::order_w-1:0] order_mem [fetch_pkg::queue_depth];
    logic [fetch_pkg::addr_w-1:0]  pc_mem    [fetch_pkg::queue_depth];
    logic [fetch_pkg::inst_w-1:0]  inst_mem  [fetch_pkg::queue_depth];

    logic [fetch_pkg::queue_ptr_w-1:0] wptr_q;
    logic [fetch_pkg::queue_ptr_w-1:0] rptr_q;
    logic [fetch_pkg::queue_ptr_w:0]   count_q;

    logic do_enq;
    logic do_deq;

    assign full_o  = (count_q == (fetch_pkg::queue_ptr_w+1)'(fetch_pkg::queue_depth));
    assign valid_o = (count_q != '0);

    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && valid_o;

    // show-ahead head
    assign order_o = order_mem[rptr_q];
    assign pc_o    = pc_mem[rptr_q];
    assign inst_o  = inst_mem[rptr_q];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_enq) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (do_deq) begin
                rptr_q <= rptr_q + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count_q <= count_q + 1'b1;
            end else if (do_deq && !do_enq) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            order_mem[wptr_q] <= enq_order_i;
            pc_mem[wptr_q]    <= enq_pc_i;
            inst_mem[wptr_q]  <= enq_inst_i;
        end
    end

endmodule

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          redirect_i,
    input  logic [fetch_pkg::addr_w-1:0]  redirect_pc_i,

    input  logic                          line_done_i,
    input  logic [fetch_pkg::line_w-1:0]  line_data_i,

    input  logic                          full_i,

    output logic                          line_req_o,
    output logic [fetch_pkg::addr_w-1:0]  line_addr_o,

    output logic                          enq_o,
    output logic [fetch_pkg::order_w-1:0] enq_order_o,
    output logic [fetch_pkg::addr_w-1:0]  enq_pc_o,
    output logic [fetch_pkg::inst_w-1:0]  enq_inst_o,

    output logic                          flush_o
);

    fetch_pkg::fetch_state_t state_q;

    logic [fetch_pkg::addr_w-1:0]  pc_q;
    logic [fetch_pkg::order_w-1:0] order_q;

    // line buffer
    logic [fetch_pkg::addr_w-fetch_pkg::line_off_w-1:0] buf_tag_q;
    logic [fetch_pkg::line_w-1:0]                       buf_data_q;
    logic                                               buf_valid_q;

    logic buf_hit;

    assign buf_hit = buf_valid_q &&
                     (pc_q[fetch_pkg::addr_w-1:fetch_pkg::line_off_w] == buf_tag_q);

    // nothing goes in while a redirect or its flush is pending
    assign enq_o = (state_q == fetch_pkg::fs_run) && buf_hit && !full_i &&
                   !redirect_i && !flush_o;

    assign enq_order_o = order_q;
    assign enq_pc_o    = pc_q;
    assign enq_inst_o  = buf_data_q[pc_q[4:2]*fetch_pkg::inst_w +: fetch_pkg::inst_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= fetch_pkg::fs_run;
            pc_q        <= fetch_pkg::reset_pc;
            order_q     <= '0;
            buf_valid_q <= 1'b0;
            line_req_o  <= 1'b0;
            flush_o     <= 1'b0;
        end else begin
            line_req_o <= 1'b0;
            flush_o    <= redirect_i;

            if (enq_o) begin
                pc_q    <= pc_q + fetch_pkg::addr_w'(4);
                order_q <= order_q + fetch_pkg::order_w'(1);
            end

            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end

            case (state_q)
                fetch_pkg::fs_run: begin
                    if (!redirect_i && !buf_hit) begin
                        line_req_o <= 1'b1;
                        state_q    <= fetch_pkg::fs_miss;
                    end
                end
                fetch_pkg::fs_miss: begin
                    // a line finishing with the redirect is still good
                    if (line_done_i) begin
                        buf_valid_q <= 1'b1;
                        state_q     <= fetch_pkg::fs_run;
                    end else if (redirect_i) begin
                        state_q <= fetch_pkg::fs_drain;
                    end
                end
                fetch_pkg::fs_drain: begin
                    // stale line is dropped
                    if (line_done_i) begin
                        state_q <= fetch_pkg::fs_run;
                    end
                end
                default: begin
                    state_q <= fetch_pkg::fs_run;
                end
            endcase
        end
    end

    // miss address is the line holding the current pc
    always_ff @(posedge clk) begin
        if ((state_q == fetch_pkg::fs_run) && !redirect_i && !buf_hit) begin
            line_addr_o <= {pc_q[fetch_pkg::addr_w-1:fetch_pkg::line_off_w],
                            {fetch_pkg::line_off_w{1'b0}}};
        end
    end

    // buffer contents
    always_ff @(posedge clk) begin
        if ((state_q == fetch_pkg::fs_miss) && line_done_i) begin
            buf_tag_q  <= line_addr_o[fetch_pkg::addr_w-1:fetch_pkg::line_off_w];
            buf_data_q <= line_data_i;
        end
    end

endmodule

// ==== verilog/burst_line_reader.sv ====
`timescale 1ns/1ps

module burst_line_reader (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          line_req_i,
    input  logic [fetch_pkg::addr_w-1:0]  line_addr_i,

    input  logic                          bmem_ready_i,
    input  logic [fetch_pkg::addr_w-1:0]  bmem_raddr_i,
    input  logic [fetch_pkg::beat_w-1:0]  bmem_rdata_i,
    input  logic                          bmem_rvalid_i,

    output logic [fetch_pkg::addr_w-1:0]  bmem_addr_o,
    output logic                          bmem_read_o,

    output logic                          line_done_o,
    output logic [fetch_pkg::line_w-1:0]  line_data_o
);

    fetch_pkg::reader_state_t state_q;

    // only the tag is stored, the low address bits are always zero
    logic [fetch_pkg::addr_w-fetch_pkg::line_off_w-1:0] tag_q;
    logic [1:0] beat_cnt_q;
    logic       beat_hit;

    assign bmem_addr_o = {tag_q, {fetch_pkg::line_off_w{1'b0}}};

    // read strobe only while memory is ready
    assign bmem_read_o = (state_q == fetch_pkg::rd_issue) && bmem_ready_i;

    // beat belongs to the line we asked for
    assign beat_hit = (state_q == fetch_pkg::rd_collect) && bmem_rvalid_i &&
                      (bmem_raddr_i[fetch_pkg::addr_w-1:fetch_pkg::line_off_w] == tag_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= fetch_pkg::rd_idle;
            beat_cnt_q  <= '0;
            line_done_o <= 1'b0;
        end else begin
            line_done_o <= 1'b0;
            case (state_q)
                fetch_pkg::rd_idle: begin
                    if (line_req_i) begin
                        state_q <= fetch_pkg::rd_issue;
                    end
                end
                fetch_pkg::rd_issue: begin
                    if (bmem_ready_i) begin
                        beat_cnt_q <= '0;
                        state_q    <= fetch_pkg::rd_collect;
                    end
                end
                fetch_pkg::rd_collect: begin
                    if (beat_hit) begin
                        beat_cnt_q <= beat_cnt_q + 2'd1;
                        if (beat_cnt_q == 2'(fetch_pkg::beats_per_line - 1)) begin
                            line_done_o <= 1'b1;
                            state_q     <= fetch_pkg::rd_idle;
                        end
                    end
                end
                default: begin
                    state_q <= fetch_pkg::rd_idle;
                end
            endcase
        end
    end

    // request address
    always_ff @(posedge clk) begin
        if ((state_q == fetch_pkg::rd_idle) && line_req_i) begin
            tag_q <= line_addr_i[fetch_pkg::addr_w-1:fetch_pkg::line_off_w];
        end
    end

    // beats land in rising address order
    always_ff @(posedge clk) begin
        if (beat_hit) begin
            line_data_o[beat_cnt_q*fetch_pkg::beat_w +: fetch_pkg::beat_w] <= bmem_rdata_i;
        end
    end

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    // widths
    localparam int addr_w   = 32;
    localparam int inst_w   = 32;
    localparam int order_w  = 64;
    localparam int beat_w   = 64;
    localparam int line_w   = 256;

    // line geometry
    localparam int beats_per_line = 4;
    localparam int line_off_w     = 5;

    // instruction queue
    localparam int queue_depth = 16;
    localparam int queue_ptr_w = $clog2(queue_depth);

    localparam logic [addr_w-1:0] reset_pc = 32'haaaaa000;

    // burst reader FSM
    typedef enum logic [1:0] {
        rd_idle,
        rd_issue,
        rd_collect
    } reader_state_t;

    // fetch controller FSM
    typedef enum logic [1:0] {
        fs_run,
        fs_miss,
        fs_drain
    } fetch_state_t;

endpackage
